// File: rv_cfg_pkg.sv
`default_nettype none

package rv_cfg_pkg;

  // Data and address width
  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int REG_AW = 5;

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

  // addi x0, x0, 0 doubles as the pipeline bubble
  localparam logic [ILEN-1:0] NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2
  } wb_src_e;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2,
    ALU_EQ     = 2'd3
  } alu_op_e;

  // Field positions inside the instruction word
  localparam int RD_LSB     = 7;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire                         flow_i,
  input  wire                         stall_i,
  input  wire                         redirect_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0] redirect_pc_i,
  output logic                        if_valid_o,
  input  wire                         if_ready_i,
  output logic [rv_cfg_pkg::XLEN-1:0] if_addr_o,
  input  wire  [rv_cfg_pkg::ILEN-1:0] if_data_i,
  output logic [rv_cfg_pkg::ILEN-1:0] id_inst_o,
  output logic [rv_cfg_pkg::XLEN-1:0] id_pc_o
);

  logic [rv_cfg_pkg::XLEN-1:0] pc_q;

  assign if_addr_o = pc_q;

  // Request stays up once out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_valid_o <= 1'b0;
      pc_q       <= rv_cfg_pkg::RESET_PC;
      id_inst_o  <= rv_cfg_pkg::NOP_INST;
    end else begin
      if_valid_o <= 1'b1;
      if (flow_i) begin
        if (redirect_i) begin
          // Word fetched this cycle is on the wrong path
          pc_q      <= redirect_pc_i;
          id_inst_o <= rv_cfg_pkg::NOP_INST;
        end else if (!stall_i) begin
          if (if_valid_o) begin
            pc_q <= pc_q + rv_cfg_pkg::PC_STEP;
          end
          id_inst_o <= if_valid_o ? if_data_i : rv_cfg_pkg::NOP_INST;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i && !stall_i) begin
      id_pc_o <= pc_q;
    end
  end

  // Address must not move under a pending request
  a_if_addr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    if_valid_o && !if_ready_i |=> $stable(if_addr_o));

endmodule

`default_nettype wire

// File: decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire                           flow_i,
  input  wire                           flush_i,
  input  wire  [rv_cfg_pkg::ILEN-1:0]   id_inst_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   id_pc_i,
  input  wire                           wb_we_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] wb_rd_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   wb_data_i,
  output logic                          stall_o,
  output rv_isa_pkg::alu_op_e           ex_op_o,
  output rv_isa_pkg::wb_src_e           ex_wb_src_o,
  output logic                          ex_we_o,
  output logic                          ex_mem_rd_o,
  output logic                          ex_mem_wr_o,
  output logic                          ex_branch_o,
  output logic                          ex_jump_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] ex_rs1_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] ex_rs2_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] ex_rd_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   ex_a_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   ex_b_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   ex_imm_o,
  output logic                          ex_use_imm_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   ex_pc_o,
  output logic [rv_cfg_pkg::ILEN-1:0]   ex_inst_o
);

  logic [rv_cfg_pkg::XLEN-1:0]   rf_q [2**rv_cfg_pkg::REG_AW];
  logic [rv_cfg_pkg::ILEN-1:0]   inst;
  logic [rv_cfg_pkg::REG_AW-1:0] id_rs1, id_rs2, rs1, rs2, rd;
  logic [rv_cfg_pkg::XLEN-1:0]   rd_a, rd_b;
  logic [rv_cfg_pkg::XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_isa_pkg::alu_op_e           d_op;
  rv_isa_pkg::wb_src_e           d_wb_src;
  logic                          d_we, d_mem_rd, d_mem_wr, d_branch, d_jump, d_use_imm;
  logic [rv_cfg_pkg::XLEN-1:0]   d_imm;

  // Load in execute feeding this instruction
  assign id_rs1  = id_inst_i[rv_isa_pkg::RS1_LSB +: rv_cfg_pkg::REG_AW];
  assign id_rs2  = id_inst_i[rv_isa_pkg::RS2_LSB +: rv_cfg_pkg::REG_AW];
  assign stall_o = ex_mem_rd_o && ex_rd_o != '0 && (ex_rd_o == id_rs1 || ex_rd_o == id_rs2);

  // Flushed or stalled slots go down as a bubble
  assign inst = (flush_i || stall_o) ? rv_cfg_pkg::NOP_INST : id_inst_i;
  assign rs1  = inst[rv_isa_pkg::RS1_LSB +: rv_cfg_pkg::REG_AW];
  assign rs2  = inst[rv_isa_pkg::RS2_LSB +: rv_cfg_pkg::REG_AW];
  assign rd   = inst[rv_isa_pkg::RD_LSB +: rv_cfg_pkg::REG_AW];

  assign imm_i = {{(rv_cfg_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(rv_cfg_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(rv_cfg_pkg::XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_u = {{(rv_cfg_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(rv_cfg_pkg::XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  always_comb begin
    d_op      = rv_isa_pkg::ALU_ADD;
    d_wb_src  = rv_isa_pkg::WB_ALU;
    d_we      = 1'b0;
    d_mem_rd  = 1'b0;
    d_mem_wr  = 1'b0;
    d_branch  = 1'b0;
    d_jump    = 1'b0;
    d_use_imm = 1'b1;
    d_imm     = imm_i;
    case (rv_isa_pkg::opcode_e'(inst[6:0]))
      rv_isa_pkg::OPC_OP: begin
        d_we      = 1'b1;
        d_use_imm = 1'b0;
        if (inst[rv_isa_pkg::FUNCT7_LSB +: 7] == rv_isa_pkg::FUNCT7_SUB) begin
          d_op = rv_isa_pkg::ALU_SUB;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: d_we = 1'b1;
      rv_isa_pkg::OPC_LUI: begin
        d_we  = 1'b1;
        d_op  = rv_isa_pkg::ALU_PASS_B;
        d_imm = imm_u;
      end
      rv_isa_pkg::OPC_LOAD: begin
        d_we     = 1'b1;
        d_mem_rd = 1'b1;
        d_wb_src = rv_isa_pkg::WB_MEM;
      end
      rv_isa_pkg::OPC_STORE: begin
        d_mem_wr = 1'b1;
        d_imm    = imm_s;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        d_op      = rv_isa_pkg::ALU_EQ;
        d_branch  = 1'b1;
        d_use_imm = 1'b0;
        d_imm     = imm_b;
      end
      rv_isa_pkg::OPC_JAL: begin
        d_we     = 1'b1;
        d_jump   = 1'b1;
        d_wb_src = rv_isa_pkg::WB_LINK;
        d_imm    = imm_j;
      end
      default: d_use_imm = 1'b0;
    endcase
  end

  // x0 is cleared by reset and never written
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rf_q[0] <= '0;
    end else if (wb_we_i && wb_rd_i != '0) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  // Write before read through the writeback bypass
  assign rd_a = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs1) ? wb_data_i : rf_q[rs1];
  assign rd_b = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs2) ? wb_data_i : rf_q[rs2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_op_o     <= rv_isa_pkg::ALU_ADD;
      ex_wb_src_o <= rv_isa_pkg::WB_ALU;
      ex_we_o     <= 1'b0;
      ex_mem_rd_o <= 1'b0;
      ex_mem_wr_o <= 1'b0;
      ex_branch_o <= 1'b0;
      ex_jump_o   <= 1'b0;
      ex_inst_o   <= rv_cfg_pkg::NOP_INST;
    end else if (flow_i) begin
      ex_op_o     <= d_op;
      ex_wb_src_o <= d_wb_src;
      ex_we_o     <= d_we;
      ex_mem_rd_o <= d_mem_rd;
      ex_mem_wr_o <= d_mem_wr;
      ex_branch_o <= d_branch;
      ex_jump_o   <= d_jump;
      ex_inst_o   <= inst;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i) begin
      ex_rs1_o     <= rs1;
      ex_rs2_o     <= rs2;
      ex_rd_o      <= rd;
      ex_a_o       <= rd_a;
      ex_b_o       <= rd_b;
      ex_imm_o     <= d_imm;
      ex_use_imm_o <= d_use_imm;
      ex_pc_o      <= id_pc_i;
    end
  end

  a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    flow_i && rs1 == '0 |=> ex_a_o == '0);

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire                           flow_i,
  input  wire  rv_isa_pkg::alu_op_e     ex_op_i,
  input  wire  rv_isa_pkg::wb_src_e     ex_wb_src_i,
  input  wire                           ex_we_i,
  input  wire                           ex_mem_rd_i,
  input  wire                           ex_mem_wr_i,
  input  wire                           ex_branch_i,
  input  wire                           ex_jump_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] ex_rs1_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] ex_rs2_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] ex_rd_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   ex_a_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   ex_b_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   ex_imm_i,
  input  wire                           ex_use_imm_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   ex_pc_i,
  input  wire  [rv_cfg_pkg::ILEN-1:0]   ex_inst_i,
  input  wire                           mem_fwd_we_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] mem_fwd_rd_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mem_fwd_data_i,
  input  wire                           wb_we_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] wb_rd_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   wb_data_i,
  output logic                          redirect_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   redirect_pc_o,
  output logic                          mm_we_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] mm_rd_o,
  output rv_isa_pkg::wb_src_e           mm_wb_src_o,
  output logic                          mm_mem_rd_o,
  output logic                          mm_mem_wr_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   mm_result_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   mm_addr_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   mm_wdata_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   mm_pc_o,
  output logic [rv_cfg_pkg::ILEN-1:0]   mm_inst_o
);

  logic [rv_cfg_pkg::XLEN-1:0] op_a, fwd_b, op_b, alu_res;

  // Memory stage is newer, so it is checked last
  function automatic logic [rv_cfg_pkg::XLEN-1:0] fwd_sel(
    input logic [rv_cfg_pkg::REG_AW-1:0] rs,
    input logic [rv_cfg_pkg::XLEN-1:0]   rf_val
  );
    logic [rv_cfg_pkg::XLEN-1:0] val;
    val = rf_val;
    if (rs != '0 && wb_we_i && wb_rd_i == rs) begin
      val = wb_data_i;
    end
    if (rs != '0 && mem_fwd_we_i && mem_fwd_rd_i == rs) begin
      val = mem_fwd_data_i;
    end
    return val;
  endfunction

  always_comb begin
    op_a  = fwd_sel(ex_rs1_i, ex_a_i);
    fwd_b = fwd_sel(ex_rs2_i, ex_b_i);
    op_b  = ex_use_imm_i ? ex_imm_i : fwd_b;
    case (ex_op_i)
      rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      rv_isa_pkg::ALU_EQ:     alu_res = {{(rv_cfg_pkg::XLEN-1){1'b0}}, op_a == op_b};
      default:                alu_res = op_a + op_b;
    endcase
  end

  // Taken BEQ or JAL, both pc relative
  assign redirect_o    = ex_jump_i || (ex_branch_i && alu_res[0]);
  assign redirect_pc_o = ex_pc_i + ex_imm_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mm_we_o     <= 1'b0;
      mm_wb_src_o <= rv_isa_pkg::WB_ALU;
      mm_mem_rd_o <= 1'b0;
      mm_mem_wr_o <= 1'b0;
      mm_inst_o   <= rv_cfg_pkg::NOP_INST;
    end else if (flow_i) begin
      mm_we_o     <= ex_we_i;
      mm_wb_src_o <= ex_wb_src_i;
      mm_mem_rd_o <= ex_mem_rd_i;
      mm_mem_wr_o <= ex_mem_wr_i;
      mm_inst_o   <= ex_inst_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i) begin
      mm_rd_o     <= ex_rd_i;
      mm_result_o <= alu_res;
      mm_addr_o   <= op_a + ex_imm_i;
      mm_wdata_o  <= fwd_b;
      mm_pc_o     <= ex_pc_i;
    end
  end

endmodule

`default_nettype wire

// File: mem_wb_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_unit (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire                           flow_i,
  input  wire                           mm_we_i,
  input  wire  [rv_cfg_pkg::REG_AW-1:0] mm_rd_i,
  input  wire  rv_isa_pkg::wb_src_e     mm_wb_src_i,
  input  wire                           mm_mem_rd_i,
  input  wire                           mm_mem_wr_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mm_result_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mm_addr_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mm_wdata_i,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mm_pc_i,
  input  wire  [rv_cfg_pkg::ILEN-1:0]   mm_inst_i,
  output logic                          mem_valid_o,
  input  wire                           mem_ready_i,
  output logic [rv_cfg_pkg::XLEN-1:0]   mem_addr_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   mem_wdata_o,
  input  wire  [rv_cfg_pkg::XLEN-1:0]   mem_rdata_i,
  output logic                          mem_wen_o,
  output logic                          mem_busy_o,
  output logic                          fwd_we_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] fwd_rd_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   fwd_data_o,
  output logic                          wb_we_o,
  output logic [rv_cfg_pkg::REG_AW-1:0] wb_rd_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   wb_data_o,
  output logic [rv_cfg_pkg::XLEN-1:0]   pc_vis_o,
  output logic [rv_cfg_pkg::ILEN-1:0]   instruction_vis_o,
  output logic                          exec_once_o
);

  logic                        done_q;
  logic [rv_cfg_pkg::XLEN-1:0] rdata_q, load_data, sel_data;
  logic [rv_cfg_pkg::XLEN-1:0] wb_pc_q;
  logic [rv_cfg_pkg::ILEN-1:0] wb_inst_q;

  // One transfer per access, even if another port holds the pipe
  assign mem_valid_o = (mm_mem_rd_i || mm_mem_wr_i) && !done_q;
  assign mem_wen_o   = mm_mem_wr_i && mem_valid_o;
  assign mem_addr_o  = mm_addr_i;
  assign mem_wdata_o = mm_wdata_i;
  assign mem_busy_o  = mem_valid_o && !mem_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else if (flow_i) begin
      done_q <= 1'b0;
    end else if (mem_valid_o && mem_ready_i) begin
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_valid_o && mem_ready_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign load_data = done_q ? rdata_q : mem_rdata_i;

  always_comb begin
    case (mm_wb_src_i)
      rv_isa_pkg::WB_MEM:  sel_data = load_data;
      rv_isa_pkg::WB_LINK: sel_data = mm_pc_i + rv_cfg_pkg::PC_STEP;
      default:             sel_data = mm_result_i;
    endcase
  end

  // Load data is not ready in time for execute
  assign fwd_we_o   = mm_we_i && !mm_mem_rd_i;
  assign fwd_rd_o   = mm_rd_i;
  assign fwd_data_o = sel_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_we_o     <= 1'b0;
      wb_inst_q   <= rv_cfg_pkg::NOP_INST;
      exec_once_o <= 1'b0;
    end else begin
      exec_once_o <= flow_i && wb_inst_q != rv_cfg_pkg::NOP_INST;
      if (flow_i) begin
        wb_we_o   <= mm_we_i;
        wb_inst_q <= mm_inst_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (flow_i) begin
      wb_rd_o           <= mm_rd_i;
      wb_data_o         <= sel_data;
      wb_pc_q           <= mm_pc_i;
      pc_vis_o          <= wb_pc_q;
      instruction_vis_o <= wb_inst_q;
    end
  end

  a_mem_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o));

endmodule

`default_nettype wire

// File: rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top (
  input  wire                         clk_i,
  input  wire                         reset_i,
  output logic                        if_valid_o,
  input  wire                         if_ready_i,
  output logic [rv_cfg_pkg::XLEN-1:0] if_addr_o,
  input  wire  [rv_cfg_pkg::ILEN-1:0] if_data_i,
  output logic                        mem_valid_o,
  input  wire                         mem_ready_i,
  output logic [rv_cfg_pkg::XLEN-1:0] mem_addr_o,
  output logic [rv_cfg_pkg::XLEN-1:0] mem_wdata_o,
  input  wire  [rv_cfg_pkg::XLEN-1:0] mem_rdata_i,
  output logic                        mem_wen_o,
  output logic [rv_cfg_pkg::XLEN-1:0] pc_vis_o,
  output logic [rv_cfg_pkg::ILEN-1:0] instruction_vis_o,
  output logic                        exec_once_o
);

  logic                          flow, stall, redirect, mem_busy;
  logic [rv_cfg_pkg::XLEN-1:0]   redirect_pc, id_pc;
  logic [rv_cfg_pkg::ILEN-1:0]   id_inst;
  // Decode to execute
  rv_isa_pkg::alu_op_e           ex_op;
  rv_isa_pkg::wb_src_e           ex_wb_src;
  logic                          ex_we, ex_mem_rd, ex_mem_wr, ex_branch, ex_jump, ex_use_imm;
  logic [rv_cfg_pkg::REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [rv_cfg_pkg::XLEN-1:0]   ex_a, ex_b, ex_imm, ex_pc;
  logic [rv_cfg_pkg::ILEN-1:0]   ex_inst;
  // Execute to memory
  rv_isa_pkg::wb_src_e           mm_wb_src;
  logic                          mm_we, mm_mem_rd, mm_mem_wr;
  logic [rv_cfg_pkg::REG_AW-1:0] mm_rd;
  logic [rv_cfg_pkg::XLEN-1:0]   mm_result, mm_addr, mm_wdata, mm_pc;
  logic [rv_cfg_pkg::ILEN-1:0]   mm_inst;
  // Forwarding and writeback
  logic                          fwd_we, wb_we;
  logic [rv_cfg_pkg::REG_AW-1:0] fwd_rd, wb_rd;
  logic [rv_cfg_pkg::XLEN-1:0]   fwd_data, wb_data;

  // Pipe moves only when no port is left waiting
  assign flow = (!if_valid_o || if_ready_i) && !mem_busy;

  fetch_unit u_fetch (
    .clk_i(clk_i), .reset_i(reset_i), .flow_i(flow), .stall_i(stall),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .if_valid_o(if_valid_o), .if_ready_i(if_ready_i),
    .if_addr_o(if_addr_o), .if_data_i(if_data_i),
    .id_inst_o(id_inst), .id_pc_o(id_pc)
  );

  decode_unit u_decode (
    .clk_i(clk_i), .reset_i(reset_i), .flow_i(flow), .flush_i(redirect),
    .id_inst_i(id_inst), .id_pc_i(id_pc),
    .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data), .stall_o(stall),
    .ex_op_o(ex_op), .ex_wb_src_o(ex_wb_src), .ex_we_o(ex_we),
    .ex_mem_rd_o(ex_mem_rd), .ex_mem_wr_o(ex_mem_wr),
    .ex_branch_o(ex_branch), .ex_jump_o(ex_jump),
    .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
    .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_imm_o(ex_imm), .ex_use_imm_o(ex_use_imm),
    .ex_pc_o(ex_pc), .ex_inst_o(ex_inst)
  );

  execute_unit u_execute (
    .clk_i(clk_i), .reset_i(reset_i), .flow_i(flow),
    .ex_op_i(ex_op), .ex_wb_src_i(ex_wb_src), .ex_we_i(ex_we),
    .ex_mem_rd_i(ex_mem_rd), .ex_mem_wr_i(ex_mem_wr),
    .ex_branch_i(ex_branch), .ex_jump_i(ex_jump),
    .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
    .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_imm_i(ex_imm), .ex_use_imm_i(ex_use_imm),
    .ex_pc_i(ex_pc), .ex_inst_i(ex_inst),
    .mem_fwd_we_i(fwd_we), .mem_fwd_rd_i(fwd_rd), .mem_fwd_data_i(fwd_data),
    .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .mm_we_o(mm_we), .mm_rd_o(mm_rd), .mm_wb_src_o(mm_wb_src),
    .mm_mem_rd_o(mm_mem_rd), .mm_mem_wr_o(mm_mem_wr),
    .mm_result_o(mm_result), .mm_addr_o(mm_addr), .mm_wdata_o(mm_wdata),
    .mm_pc_o(mm_pc), .mm_inst_o(mm_inst)
  );

  mem_wb_unit u_mem_wb (
    .clk_i(clk_i), .reset_i(reset_i), .flow_i(flow),
    .mm_we_i(mm_we), .mm_rd_i(mm_rd), .mm_wb_src_i(mm_wb_src),
    .mm_mem_rd_i(mm_mem_rd), .mm_mem_wr_i(mm_mem_wr),
    .mm_result_i(mm_result), .mm_addr_i(mm_addr), .mm_wdata_i(mm_wdata),
    .mm_pc_i(mm_pc), .mm_inst_i(mm_inst),
    .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i), .mem_wen_o(mem_wen_o), .mem_busy_o(mem_busy),
    .fwd_we_o(fwd_we), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data),
    .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
    .pc_vis_o(pc_vis_o), .instruction_vis_o(instruction_vis_o),
    .exec_once_o(exec_once_o)
  );

endmodule

`default_nettype wire

// File: tb_rv_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe;

  localparam int          ROWS_MAX = 64;
  localparam int          WAIT_MAX = 4000;
  localparam int          DRAIN    = 20;
  localparam logic [63:0] DBASE    = 64'h0000_0000_0001_0000;

  logic        clk = 1'b0;
  logic        reset;
  logic        if_valid, if_ready;
  logic [63:0] if_addr;
  logic [31:0] if_data;
  logic        mem_valid, mem_ready, mem_wen;
  logic [63:0] mem_addr, mem_wdata, mem_rdata;
  logic [63:0] pc_vis;
  logic [31:0] inst_vis;
  logic        exec_once;

  // Program table with one row per instruction slot
  logic [31:0] tab_inst  [ROWS_MAX];
  logic        tab_ret   [ROWS_MAX];
  logic        tab_store [ROWS_MAX];
  logic [63:0] tab_val   [ROWS_MAX];
  logic [63:0] tab_addr  [ROWS_MAX];
  int          n_rows;

  logic [31:0] imem [ROWS_MAX];
  logic [63:0] dmem [logic [63:0]];

  logic [63:0] exp_pc_q[$];
  logic [63:0] exp_inst_q[$];
  logic [63:0] exp_val_q[$];
  logic [63:0] exp_addr_q[$];

  bit          rand_ready;
  int          if_wait, mem_wait;
  int          errors;
  int          n_retired, n_stored;
  string       run_tag;

  always #10 clk = ~clk;

  rv_pipe_top dut (
    .clk_i(clk), .reset_i(reset),
    .if_valid_o(if_valid), .if_ready_i(if_ready),
    .if_addr_o(if_addr), .if_data_i(if_data),
    .mem_valid_o(mem_valid), .mem_ready_i(mem_ready),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata), .mem_wen_o(mem_wen),
    .pc_vis_o(pc_vis), .instruction_vis_o(inst_vis),
    .exec_once_o(exec_once)
  );

  // RV64I encodings of the supported subset
  function automatic logic [31:0] addi_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] add_inst(input int rd, input int rs1, input int rs2);
    return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] sub_inst(input int rd, input int rs1, input int rs2);
    return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_inst(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] ld_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sd_inst(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] beq_inst(input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_inst(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  // Unwritten data memory shows every address bit in the word
  function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
    return {addr[31:0], addr[63:32]} ^ 64'hc3c3_5a5a_0f0f_a5a5;
  endfunction

  function automatic logic [31:0] fetch_word(input logic [63:0] addr);
    logic [63:0] offs;
    offs = addr - rv_cfg_pkg::RESET_PC;
    if (offs < 64'(ROWS_MAX * 4)) begin
      return imem[offs[7:2]];
    end
    return rv_cfg_pkg::NOP_INST;
  endfunction

  function automatic logic [63:0] load_word(input logic [63:0] addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return fill_pattern(addr);
  endfunction

  function automatic int pick_delay();
    if (rand_ready) begin
      return int'($urandom % 32'd4);
    end
    return 0;
  endfunction

  task automatic add_row(input logic [31:0] inst, input int ret, input int store,
                         input logic [63:0] val, input logic [63:0] addr);
    tab_inst[n_rows]  = inst;
    tab_ret[n_rows]   = (ret != 0);
    tab_store[n_rows] = (store != 0);
    tab_val[n_rows]   = val;
    tab_addr[n_rows]  = addr;
    n_rows++;
  endtask

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // Skipped rows add nothing to the expected sequences
  task automatic build_expected();
    exp_pc_q.delete();
    exp_inst_q.delete();
    exp_val_q.delete();
    exp_addr_q.delete();
    for (int i = 0; i < ROWS_MAX; i++) begin
      imem[i] = (i < n_rows) ? tab_inst[i] : rv_cfg_pkg::NOP_INST;
      if (i < n_rows && tab_ret[i]) begin
        exp_pc_q.push_back(rv_cfg_pkg::RESET_PC + 64'(4 * i));
        exp_inst_q.push_back(64'(tab_inst[i]));
        if (tab_store[i]) begin
          exp_val_q.push_back(tab_val[i]);
          exp_addr_q.push_back(tab_addr[i]);
        end
      end
    end
  endtask

  task automatic check_retire();
    if (exp_pc_q.size() == 0) begin
      $display("Retirement past the end of the program at pc %h in %s", pc_vis, run_tag);
      abort_run();
    end else begin
      check_value($sformatf("%s retire %0d pc", run_tag, n_retired),
                  exp_pc_q.pop_front(), pc_vis);
      check_value($sformatf("%s retire %0d instruction", run_tag, n_retired),
                  exp_inst_q.pop_front(), 64'(inst_vis));
      n_retired++;
    end
  endtask

  task automatic check_store();
    if (exp_val_q.size() == 0) begin
      $display("Unexpected store of %h to %h in %s", mem_wdata, mem_addr, run_tag);
      abort_run();
    end else begin
      check_value($sformatf("%s store %0d address", run_tag, n_stored),
                  exp_addr_q.pop_front(), mem_addr);
      check_value($sformatf("%s store %0d value", run_tag, n_stored),
                  exp_val_q.pop_front(), mem_wdata);
      n_stored++;
    end
  endtask

  // Memory models and retire monitor
  // DUT port outputs come from registers, so a handshake is known here
  always @(negedge clk) begin
    if (if_valid && if_wait == 0) begin
      if_ready = 1'b1;
      if_data  = fetch_word(if_addr);
      if_wait  = pick_delay();
    end else begin
      if_ready = 1'b0;
      if (if_valid) begin
        if_wait = if_wait - 1;
      end
    end
    if (mem_valid && mem_wait == 0) begin
      mem_ready = 1'b1;
      mem_wait  = pick_delay();
      if (mem_wen) begin
        check_store();
        dmem[mem_addr] = mem_wdata;
      end else begin
        mem_rdata = load_word(mem_addr);
      end
    end else begin
      mem_ready = 1'b0;
      if (mem_valid) begin
        mem_wait = mem_wait - 1;
      end
    end
    if (exec_once) begin
      check_retire();
    end
  end

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (exp_pc_q.size() != 0 || exp_val_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_MAX) begin
        $display("Timeout in %s: %0d retirements and %0d stores never arrived",
                 run_tag, exp_pc_q.size(), exp_val_q.size());
        abort_run();
      end
    end
  endtask

  task automatic run_program(input string tag, input bit random_ready);
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
    end
    // Ports are idle here, so the models can be rearmed
    run_tag    = tag;
    rand_ready = random_ready;
    if_wait    = 0;
    mem_wait   = 0;
    n_retired  = 0;
    n_stored   = 0;
    dmem.delete();
    build_expected();
    check_value({tag, " reset if_valid"}, 64'd0, 64'(if_valid));
    check_value({tag, " reset mem_valid"}, 64'd0, 64'(mem_valid));
    check_value({tag, " reset mem_wen"}, 64'd0, 64'(mem_wen));
    check_value({tag, " reset exec_once"}, 64'd0, 64'(exec_once));
    reset = 1'b0;
    @(negedge clk);
    check_value({tag, " first fetch valid"}, 64'd1, 64'(if_valid));
    check_value({tag, " first fetch address"}, rv_cfg_pkg::RESET_PC, if_addr);
    wait_done();
    // Anything that retires or stores late is caught by the monitor
    for (int i = 0; i < DRAIN; i++) begin
      @(posedge clk);
    end
  endtask

  initial begin
    reset      = 1'b1;
    if_ready   = 1'b0;
    if_data    = rv_cfg_pkg::NOP_INST;
    mem_ready  = 1'b0;
    mem_rdata  = 64'd0;
    rand_ready = 1'b0;
    if_wait    = 0;
    mem_wait   = 0;
    errors     = 0;
    n_rows     = 0;
    n_retired  = 0;
    n_stored   = 0;
    run_tag    = "init";
    void'($urandom(32'hd52a));

    // ALU results with x10 as the data base
    add_row(lui_inst(10, 32'h10), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(1, 0, 100), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(2, 0, 23), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(3, 1, 2), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(3, 10, 0), 1, 1, 64'd123, DBASE);
    add_row(sub_inst(4, 1, 2), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(4, 10, 8), 1, 1, 64'd77, DBASE + 64'd8);
    add_row(lui_inst(5, 32'habcde), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(5, 10, 16), 1, 1, 64'hffff_ffff_abcd_e000, DBASE + 64'd16);
    // Dependent chain back to back
    add_row(addi_inst(6, 0, 5), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(7, 6, 6), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(8, 7, 6), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(8, 10, 24), 1, 1, 64'd15, DBASE + 64'd24);
    // Same chain spaced by fillers
    add_row(addi_inst(16, 0, 5), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(20, 0, 1), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(21, 0, 2), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(22, 0, 3), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(17, 16, 16), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(20, 0, 4), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(21, 0, 5), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(22, 0, 6), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(18, 17, 16), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(20, 0, 7), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(21, 0, 8), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(22, 0, 9), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(18, 10, 32), 1, 1, 64'd15, DBASE + 64'd32);
    // Load-use on stored data and on untouched memory
    add_row(ld_inst(9, 10, 0), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(11, 9, 1), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(11, 10, 40), 1, 1, 64'd223, DBASE + 64'd40);
    add_row(ld_inst(12, 10, 256), 1, 0, 64'd0, 64'd0);
    add_row(add_inst(13, 12, 2), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(13, 10, 48), 1, 1, fill_pattern(DBASE + 64'd256) + 64'd23,
            DBASE + 64'd48);
    // Taken branch skips two rows
    add_row(beq_inst(1, 1, 12), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(14, 0, 1), 0, 0, 64'd0, 64'd0);
    add_row(sd_inst(14, 10, 56), 0, 1, 64'd1, DBASE + 64'd56);
    add_row(addi_inst(14, 0, 7), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(14, 10, 56), 1, 1, 64'd7, DBASE + 64'd56);
    add_row(beq_inst(1, 2, 12), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(15, 0, 9), 1, 0, 64'd0, 64'd0);
    add_row(sd_inst(15, 10, 64), 1, 1, 64'd9, DBASE + 64'd64);
    // Jump at row 40 links its pc plus 4
    add_row(jal_inst(19, 12), 1, 0, 64'd0, 64'd0);
    add_row(addi_inst(19, 0, 1), 0, 0, 64'd0, 64'd0);
    add_row(sd_inst(19, 10, 72), 0, 1, 64'd1, DBASE + 64'd72);
    add_row(sd_inst(19, 10, 72), 1, 1, rv_cfg_pkg::RESET_PC + 64'd164, DBASE + 64'd72);

    run_program("ready high", 1'b0);
    run_program("random ready", 1'b1);

    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rv_cfg_pkg.sv
rv_isa_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
rv_pipe_top.sv
tb_rv_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, pass only if the pass line is printed
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sim.f --top-module tb_rv_pipe -o tb_rv_pipe &&
  ./obj_dir/tb_rv_pipe | tee /dev/stderr | grep "All tests passed" > /dev/null &&
  echo "Simulation PASSED" ||
  { echo "Simulation FAILED"; exit 1; }
